/* logic/cnn_pool_pkg.sv */
package cnn_pool_pkg;

    // ==========================================================
    // frame geometry
    // ==========================================================
    // input feature map, one channel
    localparam int FMAP_COLS = 24;
    localparam int FMAP_ROWS = 24;
    // pooled map after 2x2 stride 2
    localparam int POOL_COLS = FMAP_COLS / 2;
    localparam int POOL_ROWS = FMAP_ROWS / 2;
    // one memory entry per pooled point
    localparam int POOL_DEPTH = POOL_COLS * POOL_ROWS;

    // ==========================================================
    // widths
    // ==========================================================
    localparam int PIX_W  = 19;
    localparam int ADDR_W = 8;
    // raster position counters
    localparam int COL_W  = $clog2(FMAP_COLS);
    localparam int ROW_W  = $clog2(FMAP_ROWS);

    // ==========================================================
    // types
    // ==========================================================
    // streamed input point
    typedef struct packed {
        logic             valid;
        logic [PIX_W-1:0] data;
    } fmap_pixel_t;

    // pooled point out of the 2x2 window
    typedef struct packed {
        logic             valid;
        logic [PIX_W-1:0] data;
    } pool_result_t;

    typedef enum logic [1:0] {
        MEM_IDLE  = 2'd0,
        MEM_WRITE = 2'd1,
        MEM_READ  = 2'd2
    } mem_op_e;

    // single memory port request
    typedef struct packed {
        mem_op_e           op;
        logic [ADDR_W-1:0] addr;
        logic [PIX_W-1:0]  wdata;
    } mem_req_t;

    // host side strobes
    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
    } rd_req_t;

    typedef struct packed {
        logic             valid;
        logic [PIX_W-1:0] data;
    } rd_resp_t;

    // read agent FSM
    typedef enum logic [1:0] {
        RD_IDLE = 2'd0,
        RD_WAIT = 2'd1,
        RD_DATA = 2'd2
    } rd_state_e;

endpackage

/* logic/fmap_mem_arbiter.sv */
`timescale 1ns/100ps

module fmap_mem_arbiter (
    input  cnn_pool_pkg::mem_req_t i_wr_req,
    input  cnn_pool_pkg::mem_req_t i_rd_req,
    output logic                   o_rd_grant,
    output cnn_pool_pkg::mem_req_t o_mem_req
);
    import cnn_pool_pkg::*;

    logic wr_active;
    logic rd_pending;

    // ==========================================================
    // fixed priority, writer first
    // ==========================================================
    assign wr_active  = (i_wr_req.op == MEM_WRITE);
    assign rd_pending = (i_rd_req.op == MEM_READ);

    always_comb begin
        // port idles when nobody asks
        o_rd_grant = 1'b0;
        o_mem_req  = '{op: MEM_IDLE, addr: '0, wdata: '0};
        if (wr_active) begin
            // pooling stream has no stall, always served
            o_mem_req = i_wr_req;
        end else if (rd_pending) begin
            o_mem_req  = i_rd_req;
            o_rd_grant = 1'b1;
        end
    end

    // a granted read never shares the cycle with a write
    always_comb begin
        a_wr_excl_grant: assert final (!(wr_active && o_rd_grant))
            else $error("read granted during a write");
    end

endmodule

/* logic/fmap_result_ram.sv */
`timescale 1ns/100ps

module fmap_result_ram (
    input  logic                           clk,
    input  cnn_pool_pkg::mem_req_t         i_mem_req,
    output logic [cnn_pool_pkg::PIX_W-1:0] o_rd_data
);
    import cnn_pool_pkg::*;

    // one entry per pooled point
    logic [PIX_W-1:0] mem [POOL_DEPTH];
    logic [PIX_W-1:0] rd_data_q;

    // single port, write or read per cycle
    always_ff @(posedge clk) begin
        if (i_mem_req.op == MEM_WRITE) begin
            mem[i_mem_req.addr] <= i_mem_req.wdata;
        end else if (i_mem_req.op == MEM_READ) begin
            // one cycle read latency
            rd_data_q <= mem[i_mem_req.addr];
        end
    end

    assign o_rd_data = rd_data_q;

    // both agents must stay inside the 144 entries
    a_addr_range: assert property (@(posedge clk)
        (i_mem_req.op != MEM_IDLE) |-> (i_mem_req.addr < ADDR_W'(POOL_DEPTH)))
        else $error("memory address out of range: %0d", i_mem_req.addr);

endmodule

/* logic/host_read_agent.sv */
`timescale 1ns/100ps

module host_read_agent (
    input  logic                           clk,
    input  logic                           reset_n,
    input  cnn_pool_pkg::rd_req_t          i_rd_req,
    output cnn_pool_pkg::mem_req_t         o_mem_req,
    input  logic                           i_grant,
    input  logic [cnn_pool_pkg::PIX_W-1:0] i_rd_data,
    output cnn_pool_pkg::rd_resp_t         o_rd_resp
);
    import cnn_pool_pkg::*;

    rd_state_e         state_q;
    rd_state_e         state_d;
    logic [ADDR_W-1:0] addr_q;

    // ==========================================================
    // read FSM
    // ==========================================================
    always_comb begin
        state_d = state_q;
        case (state_q)
            RD_IDLE: begin
                if (i_rd_req.valid) begin
                    state_d = RD_WAIT;
                end
            end
            // hold the request until the arbiter lets it through
            RD_WAIT: begin
                if (i_grant) begin
                    state_d = RD_DATA;
                end
            end
            // ram data valid now, next request may follow directly
            RD_DATA: begin
                state_d = i_rd_req.valid ? RD_WAIT : RD_IDLE;
            end
            default: begin
                state_d = RD_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q <= RD_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // capture address with the strobe
    always_ff @(posedge clk) begin
        if (i_rd_req.valid) begin
            addr_q <= i_rd_req.addr;
        end
    end

    always_comb begin
        o_mem_req.op    = (state_q == RD_WAIT) ? MEM_READ : MEM_IDLE;
        o_mem_req.addr  = addr_q;
        o_mem_req.wdata = '0;
    end

    assign o_rd_resp = '{valid: (state_q == RD_DATA), data: i_rd_data};

    // host keeps one read in flight
    a_no_overlap: assert property (@(posedge clk) disable iff (!reset_n)
        i_rd_req.valid |-> state_q != RD_WAIT)
        else $error("host read request while a read is pending");

endmodule

/* logic/max_pool_2x2.sv */
`timescale 1ns/100ps

module max_pool_2x2 (
    input  logic                       clk,
    input  logic                       reset_n,
    input  cnn_pool_pkg::fmap_pixel_t  i_pixel,
    output cnn_pool_pkg::pool_result_t o_pool
);
    import cnn_pool_pkg::*;

    // unsigned max of two points
    function automatic logic [PIX_W-1:0] max_of(
        input logic [PIX_W-1:0] a,
        input logic [PIX_W-1:0] b
    );
        return (a > b) ? a : b;
    endfunction

    // ==========================================================
    // raster position
    // ==========================================================
    logic [COL_W-1:0] col_q;
    logic [ROW_W-1:0] row_q;
    logic [COL_W-1:0] col_left;
    logic             last_col;
    logic             last_row;
    logic             window_end;

    assign last_col = (col_q == COL_W'(FMAP_COLS - 1));
    assign last_row = (row_q == ROW_W'(FMAP_ROWS - 1));
    // bottom right corner of a window
    assign window_end = i_pixel.valid && row_q[0] && col_q[0];
    // left neighbour column, only read on odd columns
    assign col_left = col_q - COL_W'(1);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            col_q <= '0;
            row_q <= '0;
        end else if (i_pixel.valid) begin
            if (last_col) begin
                col_q <= '0;
                // wrap to the top of the next frame
                row_q <= last_row ? '0 : row_q + ROW_W'(1);
            end else begin
                col_q <= col_q + COL_W'(1);
            end
        end
    end

    // ==========================================================
    // line buffers
    // ==========================================================
    // buf0 fills with the current row, buf1 keeps the row above
    logic [PIX_W-1:0] line_buf0 [FMAP_COLS];
    logic [PIX_W-1:0] line_buf1 [FMAP_COLS];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < FMAP_COLS; i++) begin
                line_buf0[i] <= '0;
                line_buf1[i] <= '0;
            end
        end else if (i_pixel.valid) begin
            // first point of a row pushes the finished row up
            if (col_q == '0) begin
                line_buf1 <= line_buf0;
            end
            line_buf0[col_q] <= i_pixel.data;
        end
    end

    // ==========================================================
    // 2x2 maximum
    // ==========================================================
    logic [PIX_W-1:0] upper_max;
    logic [PIX_W-1:0] lower_max;
    logic [PIX_W-1:0] win_max;
    logic             pool_valid_q;
    logic [PIX_W-1:0] pool_data_q;

    always_comb begin
        // upper pair from the previous row
        upper_max = max_of(line_buf1[col_left], line_buf1[col_q]);
        // lower pair, right point is still on the input
        lower_max = max_of(line_buf0[col_left], i_pixel.data);
        win_max   = max_of(upper_max, lower_max);
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pool_valid_q <= 1'b0;
        end else begin
            pool_valid_q <= window_end;
        end
    end

    always_ff @(posedge clk) begin
        if (window_end) begin
            pool_data_q <= win_max;
        end
    end

    assign o_pool = '{valid: pool_valid_q, data: pool_data_q};

    // column wrap must hold for the buffer indexing
    a_col_range: assert property (@(posedge clk) disable iff (!reset_n)
        col_q <= COL_W'(FMAP_COLS - 1))
        else $error("column counter past last column: %0d", col_q);

endmodule

/* logic/pool_stage_top.sv */
`timescale 1ns/100ps

module pool_stage_top (
    input  logic                      clk,
    input  logic                      reset_n,
    input  cnn_pool_pkg::fmap_pixel_t i_pixel,
    input  cnn_pool_pkg::rd_req_t     i_rd_req,
    output cnn_pool_pkg::rd_resp_t    o_rd_resp,
    output logic                      o_frame_done
);
    import cnn_pool_pkg::*;

    // pooled stream
    pool_result_t     pool_res;
    // memory side requests
    mem_req_t         wr_req;
    mem_req_t         rd_mem_req;
    mem_req_t         ram_req;
    logic             rd_grant;
    logic [PIX_W-1:0] rd_data;

    // ==========================================================
    // stream path
    // ==========================================================
    max_pool_2x2 max_pool_2x2_inst (
        .clk     (clk),
        .reset_n (reset_n),
        .i_pixel (i_pixel),
        .o_pool  (pool_res)
    );

    pool_write_agent pool_write_agent_inst (
        .clk          (clk),
        .reset_n      (reset_n),
        .i_pool       (pool_res),
        .o_wr_req     (wr_req),
        .o_frame_done (o_frame_done)
    );

    // ==========================================================
    // host path and shared memory
    // ==========================================================
    host_read_agent host_read_agent_inst (
        .clk       (clk),
        .reset_n   (reset_n),
        .i_rd_req  (i_rd_req),
        .o_mem_req (rd_mem_req),
        .i_grant   (rd_grant),
        .i_rd_data (rd_data),
        .o_rd_resp (o_rd_resp)
    );

    fmap_mem_arbiter fmap_mem_arbiter_inst (
        .i_wr_req   (wr_req),
        .i_rd_req   (rd_mem_req),
        .o_rd_grant (rd_grant),
        .o_mem_req  (ram_req)
    );

    fmap_result_ram fmap_result_ram_inst (
        .clk       (clk),
        .i_mem_req (ram_req),
        .o_rd_data (rd_data)
    );

endmodule

/* logic/pool_write_agent.sv */
`timescale 1ns/100ps

module pool_write_agent (
    input  logic                       clk,
    input  logic                       reset_n,
    input  cnn_pool_pkg::pool_result_t i_pool,
    output cnn_pool_pkg::mem_req_t     o_wr_req,
    output logic                       o_frame_done
);
    import cnn_pool_pkg::*;

    // next pooled raster address
    logic [ADDR_W-1:0] wr_addr_q;
    logic              last_entry;

    assign last_entry = (wr_addr_q == ADDR_W'(POOL_DEPTH - 1));

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_addr_q <= '0;
        end else if (i_pool.valid) begin
            // wrap after the last entry of the frame
            wr_addr_q <= last_entry ? '0 : wr_addr_q + ADDR_W'(1);
        end
    end

    // one write per result, same cycle
    always_comb begin
        o_wr_req.op    = i_pool.valid ? MEM_WRITE : MEM_IDLE;
        o_wr_req.addr  = wr_addr_q;
        o_wr_req.wdata = i_pool.data;
    end

    // pulse with the write to entry 143
    assign o_frame_done = i_pool.valid && last_entry;

    // pooled results never come back to back
    // so a held host read loses the arbiter at most once
    a_result_gap: assert property (@(posedge clk) disable iff (!reset_n)
        i_pool.valid |=> !i_pool.valid)
        else $error("pooled results on consecutive cycles");

endmodule

/* pool_stage_top.f */
logic/cnn_pool_pkg.sv
logic/max_pool_2x2.sv
logic/pool_write_agent.sv
logic/host_read_agent.sv
logic/fmap_mem_arbiter.sv
logic/fmap_result_ram.sv
logic/pool_stage_top.sv
verif/tb_clock_gen.sv
verif/tb_pool_stage.sv

/* run_sim.sh */
#!/bin/sh
# build and run the pooling stage testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 \
    --top-module tb_pool_stage \
    -f pool_stage_top.f \
    -o tb_pool_stage_sim &&
./obj_dir/tb_pool_stage_sim || exit 1

/* verif/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen (
    output logic o_clk,
    output logic o_reset_n
);

    // 4 ns period
    initial begin
        o_clk = 1'b0;
        forever #2 o_clk = ~o_clk;
    end

    // reset low for 3 cycles, released between edges
    initial begin
        o_reset_n = 1'b0;
        repeat (3) @(posedge o_clk);
        @(negedge o_clk);
        o_reset_n = 1'b1;
    end

endmodule

/* verif/tb_pool_stage.sv */
`timescale 1ns/100ps

module tb_pool_stage;
    import cnn_pool_pkg::*;

    logic         clk;
    logic         reset_n;
    fmap_pixel_t  i_pixel;
    rd_req_t      i_rd_req;
    rd_resp_t     o_rd_resp;
    logic         o_frame_done;

    // write port seen inside the DUT
    mem_req_t     wr_mon;

    // ==========================================================
    // reference model state
    // ==========================================================
    logic [31:0]       rng;
    logic [PIX_W-1:0]  frame_pix [FMAP_COLS*FMAP_ROWS];
    logic [PIX_W-1:0]  model_max [POOL_DEPTH];
    // cycle in which each window's last point was driven
    int                done_cyc  [POOL_DEPTH];
    int                pool_idx;
    int                frames_sent;
    int                done_count;
    int                cyc;
    logic              in_last;
    logic              last_pt_d1;
    logic              streaming;
    logic [ADDR_W-1:0] exp_wr_addr;
    // outstanding host read
    logic              rd_pending;
    int                rd_age;
    int                rd_lat_max;
    logic [PIX_W-1:0]  rd_expect;

    tb_clock_gen tb_clock_gen_inst (
        .o_clk     (clk),
        .o_reset_n (reset_n)
    );

    pool_stage_top pool_stage_top_inst (
        .clk          (clk),
        .reset_n      (reset_n),
        .i_pixel      (i_pixel),
        .i_rd_req     (i_rd_req),
        .o_rd_resp    (o_rd_resp),
        .o_frame_done (o_frame_done)
    );

    assign wr_mon = pool_stage_top_inst.wr_req;

    // ==========================================================
    // failure reporting
    // ==========================================================
    task automatic stop_run();
        $display("Errors found");
        $fatal(1, "simulation stopped at first failure");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                   input logic [31:0] act_val);
        $display("** Error at %0t: %s expected %0h, got %0h", $time, name, exp_val, act_val);
        stop_run();
    endtask

    // ==========================================================
    // stimulus helpers
    // ==========================================================
    function automatic logic [31:0] lcg_next();
        rng = rng * 32'd1664525 + 32'd1013904223;
        return rng;
    endfunction

    // random point, or full scale at one rotating spot of some windows
    function automatic logic [PIX_W-1:0] pixel_value(input int r, input int c);
        int wr;
        int wc;
        int pos;
        wr  = r / 2;
        wc  = c / 2;
        pos = (r % 2) * 2 + (c % 2);
        if ((wr + wc) % 5 == 0 && pos == wc % 4) begin
            return {PIX_W{1'b1}};
        end
        return PIX_W'(lcg_next() >> 13);
    endfunction

    task automatic stream_frame(input logic use_gaps);
        int r;
        int c;
        int idx;
        int win;
        int gap_n;
        logic [PIX_W-1:0] d;
        logic [PIX_W-1:0] best;
        pool_idx = 0;
        for (r = 0; r < FMAP_ROWS; r++) begin
            for (c = 0; c < FMAP_COLS; c++) begin
                gap_n = use_gaps ? int'(lcg_next() % 32'd4) : 0;
                repeat (gap_n) begin
                    @(negedge clk);
                    i_pixel = '0;
                    in_last = 1'b0;
                end
                idx = r * FMAP_COLS + c;
                d   = pixel_value(r, c);
                frame_pix[idx] = d;
                @(negedge clk);
                i_pixel = '{valid: 1'b1, data: d};
                in_last = (idx == FMAP_COLS * FMAP_ROWS - 1);
                // bottom right point closes the window
                if (r % 2 == 1 && c % 2 == 1) begin
                    best = d;
                    if (frame_pix[idx - 1] > best) begin
                        best = frame_pix[idx - 1];
                    end
                    if (frame_pix[idx - FMAP_COLS] > best) begin
                        best = frame_pix[idx - FMAP_COLS];
                    end
                    if (frame_pix[idx - FMAP_COLS - 1] > best) begin
                        best = frame_pix[idx - FMAP_COLS - 1];
                    end
                    win = (r / 2) * POOL_COLS + c / 2;
                    model_max[win] = best;
                    done_cyc[win]  = cyc;
                    pool_idx       = win + 1;
                end
            end
        end
        @(negedge clk);
        i_pixel = '0;
        in_last = 1'b0;
        frames_sent++;
    endtask

    task automatic host_read(input int addr);
        int wait_n;
        @(negedge clk);
        i_rd_req  = '{valid: 1'b1, addr: ADDR_W'(addr)};
        rd_expect = model_max[addr];
        @(negedge clk);
        i_rd_req = '0;
        wait_n   = 0;
        while (rd_pending) begin
            if (wait_n > 8) begin
                $display("timeout waiting for the read response of address %0d", addr);
                stop_run();
            end
            @(negedge clk);
            wait_n++;
        end
    endtask

    task automatic read_all();
        int a;
        for (a = 0; a < POOL_DEPTH; a++) begin
            host_read(a);
        end
    endtask

    // only windows written more than 2 cycles ago are read
    task automatic reads_while_streaming();
        int a;
        int loops;
        loops = 0;
        while (streaming) begin
            if (loops > 20000) begin
                $display("streaming never finished during concurrent reads");
                stop_run();
            end
            a = (pool_idx > 0) ? int'(lcg_next() % 32'(pool_idx)) : 0;
            if (pool_idx > 0 && cyc - done_cyc[a] > 2) begin
                host_read(a);
            end else begin
                @(negedge clk);
            end
            loops++;
        end
    endtask

    task automatic wait_frame_done();
        int wait_n;
        wait_n = 0;
        while (done_count < frames_sent) begin
            if (wait_n > 16) begin
                $display("frame done strobe missing after frame %0d", frames_sent);
                stop_run();
            end
            @(negedge clk);
            wait_n++;
        end
    endtask

    task automatic wait_reset();
        int wait_n;
        wait_n = 0;
        while (!reset_n) begin
            if (wait_n > 10) begin
                $display("reset never released");
                stop_run();
            end
            @(negedge clk);
            wait_n++;
        end
    endtask

    // ==========================================================
    // event tracking
    // ==========================================================
    always @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cyc         <= 0;
            last_pt_d1  <= 1'b0;
            done_count  <= 0;
            exp_wr_addr <= '0;
            rd_pending  <= 1'b0;
            rd_age      <= 0;
        end else begin
            cyc        <= cyc + 1;
            last_pt_d1 <= i_pixel.valid && in_last;
            if (o_frame_done) begin
                done_count <= done_count + 1;
            end
            // pooled raster address, wraps per frame
            if (wr_mon.op == MEM_WRITE) begin
                exp_wr_addr <= (exp_wr_addr == ADDR_W'(POOL_DEPTH - 1)) ? '0
                                                                         : exp_wr_addr + 8'd1;
            end
            if (i_rd_req.valid) begin
                rd_pending <= 1'b1;
                rd_age     <= 1;
            end else if (o_rd_resp.valid) begin
                rd_pending <= 1'b0;
            end else if (rd_pending) begin
                rd_age <= rd_age + 1;
            end
        end
    end

    // ==========================================================
    // checks
    // ==========================================================
    // frame done one clock after the final point is taken
    a_frame_done: assert property (@(posedge clk) disable iff (!reset_n)
        o_frame_done == last_pt_d1)
        else report_mismatch("o_frame_done", 32'($sampled(last_pt_d1)),
                             32'($sampled(o_frame_done)));

    a_wr_addr: assert property (@(posedge clk) disable iff (!reset_n)
        (wr_mon.op == MEM_WRITE) |-> (wr_mon.addr == exp_wr_addr))
        else report_mismatch("wr_req.addr", 32'($sampled(exp_wr_addr)),
                             32'($sampled(wr_mon.addr)));

    a_wr_data: assert property (@(posedge clk) disable iff (!reset_n)
        (wr_mon.op == MEM_WRITE) |-> (wr_mon.wdata == model_max[exp_wr_addr]))
        else report_mismatch("wr_req.wdata", 32'(model_max[$sampled(exp_wr_addr)]),
                             32'($sampled(wr_mon.wdata)));

    // no response without a request in flight
    a_resp_owned: assert property (@(posedge clk) disable iff (!reset_n)
        o_rd_resp.valid |-> rd_pending)
        else report_mismatch("o_rd_resp.valid", 32'd0, 32'($sampled(o_rd_resp.valid)));

    a_resp_data: assert property (@(posedge clk) disable iff (!reset_n)
        o_rd_resp.valid |-> (o_rd_resp.data == rd_expect))
        else report_mismatch("o_rd_resp.data", 32'($sampled(rd_expect)),
                             32'($sampled(o_rd_resp.data)));

    // 2 cycles when idle, one more if a write took the port
    a_resp_latency: assert property (@(posedge clk) disable iff (!reset_n)
        o_rd_resp.valid |-> (rd_age >= 2 && rd_age <= rd_lat_max))
        else report_mismatch("read latency", 32'($sampled(rd_lat_max)),
                             32'($sampled(rd_age)));

    // ==========================================================
    // test sequence
    // ==========================================================
    initial begin
        int k;
        i_pixel     = '0;
        i_rd_req    = '0;
        in_last     = 1'b0;
        streaming   = 1'b0;
        rng         = 32'hdcd7_608c;
        rd_lat_max  = 2;
        rd_expect   = '0;
        pool_idx    = 0;
        frames_sent = 0;
        for (k = 0; k < POOL_DEPTH; k++) begin
            model_max[k] = '0;
            done_cyc[k]  = 0;
        end
        wait_reset();

        // empty memory straight after reset
        host_read(0);
        host_read(77);
        host_read(143);

        // two back to back frames, full readback after the first
        stream_frame(1'b0);
        wait_frame_done();
        read_all();
        stream_frame(1'b0);
        wait_frame_done();

        // gapped frame with host reads running alongside
        rd_lat_max = 3;
        streaming  = 1'b1;
        fork
            begin
                stream_frame(1'b1);
                streaming = 1'b0;
            end
            reads_while_streaming();
        join
        wait_frame_done();
        rd_lat_max = 2;
        read_all();

        repeat (4) @(negedge clk);
        $display("No errors");
        $finish;
    end

endmodule
